// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the load/store pipe testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -f sim.f --top-module lsu_pipe_tb -Mdir obj_dir

./obj_dir/Vlsu_pipe_tb

// ==== sim.f ====
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/lsu_data_ram.sv
source/lsu_result.sv
source/lsu_pipe.sv
sim/lsu_pipe_chk.sv
sim/lsu_pipe_tb.sv

// ==== sim/lsu_pipe_chk.sv ====
`timescale 1ns/1ps

module lsu_pipe_chk (
  input logic                i_clk,
  input logic                i_reset_n,
  input lsu_pkg::lsu_issue_t i_issue,
  input lsu_pkg::lsu_done_t  i_done
);

  // Issue seen at edge k is registered out at edge k+3, sampled one edge later
  a_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done.valid == $past(i_issue.valid, 4))
    else $error("completion valid does not follow issue valid");

  a_wr_or_except: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_done.wr_valid && i_done.except_valid))
    else $error("writeback and exception raised together");

  // No writeback to x0
  a_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done.wr_valid |-> (i_done.rd != '0))
    else $error("writeback to register x0");

endmodule

bind lsu_pipe lsu_pipe_chk u_chk (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_issue   (i_issue),
  .i_done    (o_done)
);

// ==== sim/lsu_pipe_tb.sv ====
`timescale 1ns/1ps

module lsu_pipe_tb;

  localparam logic [6:0] ld  = lsu_pkg::opc_load;
  localparam logic [6:0] st  = lsu_pkg::opc_store;
  localparam logic [6:0] alu = 7'b0110011;  // Register ALU op, not a memory access

  // Four edges from the drive to the k+3 register, then half a period to the negedge
  localparam int done_lat_ns = 4 * 8 + 4;

  typedef struct packed {
    logic [6:0]  op;
    logic [2:0]  funct3;
    logic [31:0] rs1;
    logic [11:0] offset;
    logic [31:0] rs2;     // Store word, zero picks a random one
    logic [4:0]  rd;
    logic [3:0]  cause;   // Expected exception cause
  } stim_t;

  logic                i_clk;
  logic                i_reset_n;
  lsu_pkg::lsu_issue_t i_issue;
  lsu_pkg::lsu_done_t  o_done;

  stim_t              stim_q [$];
  lsu_pkg::lsu_done_t exp_q [$];
  time                issue_t_q [$];
  lsu_pkg::xlen_t     shadow [lsu_pkg::ram_depth];
  lsu_pkg::xlen_t     rng = 32'hd62f;
  int                 cycle = 0;
  int                 timeout_cycles = 0;

  lsu_pipe dut0 (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .o_done    (o_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_field(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic lsu_pkg::xlen_t xorshift32(input lsu_pkg::xlen_t x);
    lsu_pkg::xlen_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic stim_t stim_row(input logic [6:0] op, input logic [2:0] f3,
                                     input logic [31:0] rs1, input logic [11:0] off,
                                     input logic [31:0] rs2, input logic [4:0] rd,
                                     input logic [3:0] cause);
    stim_t e;
    e = '{op: op, funct3: f3, rs1: rs1, offset: off, rs2: rs2, rd: rd, cause: cause};
    return e;
  endfunction

  function automatic lsu_pkg::inst_t make_inst(input stim_t e);
    lsu_pkg::inst_t w;
    if (e.op == st) begin
      w = {e.offset[11:5], 5'd2, 5'd1, e.funct3, e.offset[4:0], e.op};  // S-type
    end else begin
      w = {e.offset, 5'd1, e.funct3, e.rd, e.op};
    end
    return w;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model, byte addressed over the shadow RAM
  // ----------------------------------------------------------------------
  function automatic lsu_pkg::lsu_done_t predict(input stim_t e, input lsu_pkg::xlen_t wdata,
                                                 input int idx);
    lsu_pkg::lsu_done_t r;
    logic [31:0] addr;
    logic [31:0] ba;
    logic [31:0] val;
    int          nbytes;
    int          lane;
    logic        is_ld;
    logic        is_st;
    logic        legal;
    logic        aligned;
    is_ld   = (e.op == ld);
    is_st   = (e.op == st);
    legal   = (is_ld && (e.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})) ||
              (is_st && (e.funct3 inside {3'd0, 3'd1, 3'd2}));
    nbytes  = 1 << e.funct3[1:0];
    addr    = e.rs1 + {{20{e.offset[11]}}, e.offset};
    aligned = ((addr & 32'(nbytes - 1)) == '0);
    val     = '0;
    if (legal && aligned) begin
      for (int i = 0; i < nbytes; i++) begin
        ba   = addr + i;
        lane = int'(ba[1:0]);
        if (is_st) begin
          shadow[ba[9:2]][8*lane +: 8] = wdata[8*i +: 8];  // Bits above 9 alias
        end else begin
          val[8*i +: 8] = shadow[ba[9:2]][8*lane +: 8];
        end
      end
      if (is_ld && !e.funct3[2] && nbytes < 4 && val[8*nbytes-1]) begin
        for (int i = nbytes; i < 4; i++) begin
          val[8*i +: 8] = 8'hff;
        end
      end
    end
    r              = '0;
    r.valid        = 1'b1;
    r.tag          = lsu_pkg::tag_t'(idx);
    r.rd           = e.rd;
    r.except_valid = !legal || !aligned;
    r.cause        = e.cause;
    r.wr_valid     = is_ld && legal && aligned && (e.rd != '0);
    r.data         = r.wr_valid ? val : '0;
    return r;
  endfunction

  initial begin
    stim_q.push_back(stim_row(st, 3'd2, 32'h100, 12'h000, 32'h0, 5'd0, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd2, 32'h100, 12'h000, 32'h0, 5'd5, 4'd0));  // Back to back
    stim_q.push_back(stim_row(st, 3'd2, 32'h0f0, 12'h014, 32'h0, 5'd0, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd2, 32'h108, 12'hffc, 32'h0, 5'd6, 4'd0));
    stim_q.push_back(stim_row(st, 3'd2, 32'h200, 12'h000, 32'h1122_3344, 5'd0, 4'd0));
    stim_q.push_back(stim_row(st, 3'd0, 32'h200, 12'h001, 32'haaaa_aa85, 5'd0, 4'd0));
    stim_q.push_back(stim_row(st, 3'd1, 32'h200, 12'h002, 32'h1234_f00d, 5'd0, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd0, 32'h201, 12'h000, 32'h0, 5'd7, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd4, 32'h201, 12'h000, 32'h0, 5'd8, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd1, 32'h200, 12'h002, 32'h0, 5'd9, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd5, 32'h204, 12'hffe, 32'h0, 5'd10, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd0, 32'h200, 12'h000, 32'h0, 5'd11, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd1, 32'h200, 12'h000, 32'h0, 5'd12, 4'd0));
    // Misaligned accesses
    stim_q.push_back(stim_row(ld, 3'd1, 32'h201, 12'h000, 32'h0, 5'd13, 4'd4));
    stim_q.push_back(stim_row(ld, 3'd2, 32'h202, 12'h000, 32'h0, 5'd14, 4'd4));
    stim_q.push_back(stim_row(st, 3'd1, 32'h203, 12'h000, 32'h0, 5'd0, 4'd6));
    stim_q.push_back(stim_row(st, 3'd2, 32'h200, 12'h001, 32'h0, 5'd0, 4'd6));
    stim_q.push_back(stim_row(ld, 3'd2, 32'h200, 12'h000, 32'h0, 5'd15, 4'd0));
    // Illegal encodings
    stim_q.push_back(stim_row(ld, 3'd3, 32'h100, 12'h000, 32'h0, 5'd16, 4'd2));
    stim_q.push_back(stim_row(ld, 3'd6, 32'h100, 12'h000, 32'h0, 5'd17, 4'd2));
    stim_q.push_back(stim_row(st, 3'd4, 32'h100, 12'h000, 32'h0, 5'd0, 4'd2));
    stim_q.push_back(stim_row(alu, 3'd0, 32'h100, 12'h000, 32'h0, 5'd18, 4'd2));
    stim_q.push_back(stim_row(st, 3'd7, 32'h101, 12'h000, 32'h0, 5'd0, 4'd2));
    stim_q.push_back(stim_row(ld, 3'd2, 32'h100, 12'h000, 32'h0, 5'd19, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd2, 32'h104, 12'h000, 32'h0, 5'd0, 4'd0));   // x0
    stim_q.push_back(stim_row(ld, 3'd2, 32'h600, 12'h000, 32'h0, 5'd20, 4'd0));  // Alias
    stim_q.push_back(stim_row(st, 3'd0, 32'h108, 12'hffd, 32'h0, 5'd0, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd4, 32'h105, 12'h000, 32'h0, 5'd21, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd1, 32'h104, 12'h000, 32'h0, 5'd22, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd5, 32'h106, 12'h000, 32'h0, 5'd23, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd0, 32'h107, 12'h000, 32'h0, 5'd24, 4'd0));
    stim_q.push_back(stim_row(ld, 3'd0, 32'h100, 12'h000, 32'h0, 5'd0, 4'd0));
    timeout_cycles = stim_q.size() + 20;
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    lsu_pkg::lsu_issue_t iss;
    i_reset_n = 1'b0;
    i_issue   = '0;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int n = 0; n < stim_q.size(); n++) begin
      iss       = '0;
      iss.valid = 1'b1;
      iss.inst  = make_inst(stim_q[n]);
      iss.rs1   = stim_q[n].rs1;
      iss.rd    = stim_q[n].rd;
      iss.tag   = lsu_pkg::tag_t'(n);
      rng       = xorshift32(rng);
      iss.rs2   = (stim_q[n].rs2 != '0) ? stim_q[n].rs2 : rng;
      exp_q.push_back(predict(stim_q[n], iss.rs2, n));
      @(posedge i_clk);
      i_issue <= iss;
      issue_t_q.push_back($time);
    end
    @(posedge i_clk);
    i_issue <= '0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (4) @(posedge i_clk);
    $display("Done: no errors");
    $finish;
  end

  // Completions, sampled away from the active edge
  always @(negedge i_clk) begin
    lsu_pkg::lsu_done_t exp;
    string              who;
    time                t_issue;
    if (i_reset_n && o_done.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("a completion arrived with no instruction outstanding");
      end else begin
        exp     = exp_q.pop_front();
        t_issue = issue_t_q.pop_front();
        who     = $sformatf("entry %0d", exp.tag);
        compare_field({who, " latency ns"}, 32'($time - t_issue), 32'(done_lat_ns));
        compare_field({who, " tag"}, 32'(o_done.tag), 32'(exp.tag));
        compare_field({who, " except_valid"}, 32'(o_done.except_valid),
                      32'(exp.except_valid));
        compare_field({who, " cause"}, 32'(o_done.cause), 32'(exp.cause));
        compare_field({who, " wr_valid"}, 32'(o_done.wr_valid), 32'(exp.wr_valid));
        compare_field({who, " rd"}, 32'(o_done.rd), 32'(exp.rd));
        compare_field({who, " data"}, o_done.data, exp.data);
      end
    end
  end

  always @(posedge i_clk) begin
    if (i_reset_n) begin
      cycle = cycle + 1;
      if (cycle > timeout_cycles) begin
        abort_run("timeout, the pipe stopped returning completions");
      end
    end
  end

endmodule

// ==== source/lsu_data_ram.sv ====
`timescale 1ns/1ps

module lsu_data_ram (
  input  logic               i_clk,
  input  logic               i_we,
  input  lsu_pkg::byte_en_t  i_be,
  input  lsu_pkg::ram_addr_t i_addr,
  input  lsu_pkg::xlen_t     i_wdata,
  output lsu_pkg::xlen_t     o_rdata
);

  localparam int n_bytes = lsu_pkg::xlen_w / 8;

  lsu_pkg::xlen_t r_mem [lsu_pkg::ram_depth];

  // Per-lane write
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < n_bytes; b++) begin
      if (i_we && i_be[b]) begin
        r_mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
      end
    end
  end

  // Registered read, old data on collision
  always_ff @(posedge i_clk) begin
    o_rdata <= r_mem[i_addr];
  end

endmodule

// ==== source/lsu_decode.sv ====
`timescale 1ns/1ps

module lsu_decode (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  lsu_pkg::lsu_issue_t i_issue,
  output lsu_pkg::lsu_ctrl_t  o_ctrl
);

  lsu_pkg::lsu_issue_t r_issue;
  logic [6:0]          w_opcode;
  logic [2:0]          w_funct3;

  // EX0 issue register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_issue <= '0;
    end else begin
      r_issue <= i_issue;
    end
  end

  assign w_opcode = r_issue.inst[6:0];
  assign w_funct3 = r_issue.inst[14:12];

  // ----------------------------------------------------------------------
  // Access type decode
  // ----------------------------------------------------------------------
  always_comb begin
    o_ctrl.valid   = r_issue.valid;
    o_ctrl.op      = lsu_pkg::op_none;
    o_ctrl.size    = lsu_pkg::size_w;
    o_ctrl.sign    = 1'b0;
    o_ctrl.illegal = 1'b1;
    o_ctrl.inst    = r_issue.inst;
    o_ctrl.rs1     = r_issue.rs1;
    o_ctrl.rs2     = r_issue.rs2;
    o_ctrl.rd      = r_issue.rd;
    o_ctrl.tag     = r_issue.tag;

    if (w_opcode == lsu_pkg::opc_load) begin
      o_ctrl.illegal = 1'b0;
      o_ctrl.op      = lsu_pkg::op_load;
      case (w_funct3)
        lsu_pkg::f3_b: begin
          o_ctrl.size = lsu_pkg::size_b;
          o_ctrl.sign = 1'b1;
        end
        lsu_pkg::f3_h: begin
          o_ctrl.size = lsu_pkg::size_h;
          o_ctrl.sign = 1'b1;
        end
        lsu_pkg::f3_w:  o_ctrl.size = lsu_pkg::size_w;
        lsu_pkg::f3_bu: o_ctrl.size = lsu_pkg::size_b;
        lsu_pkg::f3_hu: o_ctrl.size = lsu_pkg::size_h;
        default: begin
          o_ctrl.illegal = 1'b1;
          o_ctrl.op      = lsu_pkg::op_none;
        end
      endcase
    end else if (w_opcode == lsu_pkg::opc_store) begin
      o_ctrl.illegal = 1'b0;
      o_ctrl.op      = lsu_pkg::op_store;
      case (w_funct3)
        lsu_pkg::f3_b: o_ctrl.size = lsu_pkg::size_b;
        lsu_pkg::f3_h: o_ctrl.size = lsu_pkg::size_h;
        lsu_pkg::f3_w: o_ctrl.size = lsu_pkg::size_w;
        default: begin
          o_ctrl.illegal = 1'b1;  // No unsigned stores
          o_ctrl.op      = lsu_pkg::op_none;
        end
      endcase
    end
  end

endmodule

// ==== source/lsu_execute.sv ====
`timescale 1ns/1ps

module lsu_execute (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  lsu_pkg::lsu_ctrl_t  i_ctrl,
  output logic                o_ram_we,
  output lsu_pkg::byte_en_t   o_ram_be,
  output lsu_pkg::ram_addr_t  o_ram_addr,
  output lsu_pkg::xlen_t      o_ram_wdata,
  output lsu_pkg::lsu_mem_t   o_mem
);

  lsu_pkg::lsu_ctrl_t r_ctrl;
  lsu_pkg::xlen_t     w_imm;
  lsu_pkg::xlen_t     w_addr;
  lsu_pkg::byte_en_t  w_be_base;
  lsu_pkg::cause_t    w_cause;
  logic               w_misalign;
  logic               w_except;

  // EX1 control register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ctrl <= '0;
    end else begin
      r_ctrl <= i_ctrl;
    end
  end

  // ----------------------------------------------------------------------
  // Address generation
  // ----------------------------------------------------------------------
  always_comb begin
    if (r_ctrl.op == lsu_pkg::op_store) begin
      w_imm = {{20{r_ctrl.inst[31]}}, r_ctrl.inst[31:25], r_ctrl.inst[11:7]};  // S-type
    end else begin
      w_imm = {{20{r_ctrl.inst[31]}}, r_ctrl.inst[31:20]};                     // I-type
    end
  end

  assign w_addr = r_ctrl.rs1 + w_imm;

  always_comb begin
    case (r_ctrl.size)
      lsu_pkg::size_b: w_misalign = 1'b0;
      lsu_pkg::size_h: w_misalign = w_addr[0];
      default:         w_misalign = |w_addr[1:0];
    endcase
  end

  // Illegal wins over misalignment
  assign w_except = r_ctrl.valid & (r_ctrl.illegal | w_misalign);
  assign w_cause  = r_ctrl.illegal                  ? lsu_pkg::cause_illegal     :
                    (r_ctrl.op == lsu_pkg::op_store) ? lsu_pkg::cause_st_misalign :
                                                       lsu_pkg::cause_ld_misalign;

  // Byte lanes for the store
  always_comb begin
    case (r_ctrl.size)
      lsu_pkg::size_b: w_be_base = 4'b0001;
      lsu_pkg::size_h: w_be_base = 4'b0011;
      default:         w_be_base = 4'b1111;
    endcase
  end

  assign o_ram_we    = r_ctrl.valid & (r_ctrl.op == lsu_pkg::op_store) & ~w_except;
  assign o_ram_be    = w_be_base << w_addr[1:0];
  assign o_ram_addr  = w_addr[lsu_pkg::ram_addr_w+1:2];  // Upper bits alias
  assign o_ram_wdata = r_ctrl.rs2 << {w_addr[1:0], 3'b000};

  // EX1 to EX2 register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_mem <= '0;
    end else begin
      o_mem.valid        <= r_ctrl.valid;
      o_mem.op           <= r_ctrl.op;
      o_mem.size         <= r_ctrl.size;
      o_mem.sign         <= r_ctrl.sign;
      o_mem.rd           <= r_ctrl.rd;
      o_mem.tag          <= r_ctrl.tag;
      o_mem.except_valid <= w_except;
      o_mem.cause        <= w_except ? w_cause : '0;
      o_mem.offset       <= w_addr[1:0];
    end
  end

endmodule

// ==== source/lsu_pipe.sv ====
`timescale 1ns/1ps

module lsu_pipe (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  lsu_pkg::lsu_issue_t i_issue,
  output lsu_pkg::lsu_done_t  o_done
);

  lsu_pkg::lsu_ctrl_t  w_ctrl;
  lsu_pkg::lsu_mem_t   w_mem;
  logic                w_ram_we;
  lsu_pkg::byte_en_t   w_ram_be;
  lsu_pkg::ram_addr_t  w_ram_addr;
  lsu_pkg::xlen_t      w_ram_wdata;
  lsu_pkg::xlen_t      w_ram_rdata;

  lsu_decode u_decode (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .o_ctrl    (w_ctrl)
  );

  lsu_execute u_execute (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_ctrl      (w_ctrl),
    .o_ram_we    (w_ram_we),
    .o_ram_be    (w_ram_be),
    .o_ram_addr  (w_ram_addr),
    .o_ram_wdata (w_ram_wdata),
    .o_mem       (w_mem)
  );

  lsu_data_ram u_data_ram (
    .i_clk   (i_clk),
    .i_we    (w_ram_we),
    .i_be    (w_ram_be),
    .i_addr  (w_ram_addr),
    .i_wdata (w_ram_wdata),
    .o_rdata (w_ram_rdata)
  );

  lsu_result u_result (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_mem     (w_mem),
    .i_rdata   (w_ram_rdata),
    .o_done    (o_done)
  );

endmodule

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  // ----------------------------------------------------------------------
  // Widths and sizes
  // ----------------------------------------------------------------------
  localparam int xlen_w     = 32;
  localparam int ram_depth  = 256;
  localparam int ram_addr_w = 8;
  localparam int tag_w      = 6;

  // RV32I memory opcodes
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;

  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;  // Load only
  localparam logic [2:0] f3_hu = 3'b101;  // Load only

  // Exception causes, mcause encoding
  localparam logic [3:0] cause_illegal     = 4'd2;
  localparam logic [3:0] cause_ld_misalign = 4'd4;
  localparam logic [3:0] cause_st_misalign = 4'd6;

  typedef logic [xlen_w-1:0]     xlen_t;
  typedef logic [31:0]           inst_t;
  typedef logic [tag_w-1:0]      tag_t;
  typedef logic [4:0]            reg_idx_t;
  typedef logic [ram_addr_w-1:0] ram_addr_t;
  typedef logic [xlen_w/8-1:0]   byte_en_t;
  typedef logic [3:0]            cause_t;

  typedef enum logic [1:0] {
    op_none,
    op_load,
    op_store
  } lsu_op_e;

  typedef enum logic [1:0] {
    size_b,
    size_h,
    size_w
  } lsu_size_e;

  // ----------------------------------------------------------------------
  // Stage records
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic     valid;
    inst_t    inst;
    xlen_t    rs1;
    xlen_t    rs2;
    reg_idx_t rd;
    tag_t     tag;
  } lsu_issue_t;

  // Decoded control, inst kept for the offset
  typedef struct packed {
    logic      valid;
    lsu_op_e   op;
    lsu_size_e size;
    logic      sign;     // 1 for LB/LH
    logic      illegal;
    inst_t     inst;
    xlen_t     rs1;
    xlen_t     rs2;
    reg_idx_t  rd;
    tag_t      tag;
  } lsu_ctrl_t;

  typedef struct packed {
    logic      valid;
    lsu_op_e   op;
    lsu_size_e size;
    logic      sign;
    reg_idx_t  rd;
    tag_t      tag;
    logic      except_valid;
    cause_t    cause;
    logic [1:0] offset;  // Byte lane within the word
  } lsu_mem_t;

  typedef struct packed {
    logic     valid;
    tag_t     tag;
    logic     except_valid;
    cause_t   cause;
    logic     wr_valid;
    reg_idx_t rd;
    xlen_t    data;
  } lsu_done_t;

endpackage

// ==== source/lsu_result.sv ====
`timescale 1ns/1ps

module lsu_result (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  lsu_pkg::lsu_mem_t  i_mem,
  input  lsu_pkg::xlen_t     i_rdata,
  output lsu_pkg::lsu_done_t o_done
);

  localparam int xw = lsu_pkg::xlen_w;

  lsu_pkg::xlen_t w_shifted;
  lsu_pkg::xlen_t w_ext;
  logic           w_wr_valid;

  // ----------------------------------------------------------------------
  // Lane extraction and extension
  // ----------------------------------------------------------------------
  assign w_shifted = i_rdata >> {i_mem.offset, 3'b000};

  always_comb begin
    case (i_mem.size)
      lsu_pkg::size_b: begin
        if (i_mem.sign) begin
          w_ext = {{(xw-8){w_shifted[7]}}, w_shifted[7:0]};
        end else begin
          w_ext = {{(xw-8){1'b0}}, w_shifted[7:0]};
        end
      end
      lsu_pkg::size_h: begin
        if (i_mem.sign) begin
          w_ext = {{(xw-16){w_shifted[15]}}, w_shifted[15:0]};
        end else begin
          w_ext = {{(xw-16){1'b0}}, w_shifted[15:0]};
        end
      end
      default: w_ext = w_shifted;  // Full word
    endcase
  end

  // No writeback to x0
  assign w_wr_valid = i_mem.valid & (i_mem.op == lsu_pkg::op_load) &
                      ~i_mem.except_valid & (i_mem.rd != '0);

  // ----------------------------------------------------------------------
  // Completion record
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done <= '0;
    end else begin
      o_done.valid        <= i_mem.valid;
      o_done.tag          <= i_mem.tag;
      o_done.except_valid <= i_mem.valid & i_mem.except_valid;
      o_done.cause        <= i_mem.cause;
      o_done.wr_valid     <= w_wr_valid;
      o_done.rd           <= i_mem.rd;
      o_done.data         <= w_wr_valid ? w_ext : '0;
    end
  end

endmodule
